/* sim.f */
design/rvc_pkg.sv
design/lane_ifs.sv
design/fetch_aligner.sv
design/rvc_expander.sv
design/lane_packer.sv
design/fetch_expand_top.sv
verif/expand_assertions.sv
verif/expand_checker.sv
verif/tb_fetch_expand.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch expansion testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_fetch_expand \
	-o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
	exit 1
fi

exit 0

/* verif/tb_fetch_expand.sv */
`timescale 1ns/1ps

module tb_fetch_expand;

	localparam int n_fixed = 12;
	localparam int n_rand = 4;
	localparam int n_entries = n_fixed + n_rand;

	logic clk;
	logic reset;
	logic fetch_valid;
	logic flush;
	logic [63:0] fetch_block;
	logic out_valid;
	logic [2:0] out_count;
	logic [3:0][31:0] out_instr;
	logic [3:0] out_is_32bit;
	logic [3:0] out_illegal;
	logic [3:0] out_straddle;

	logic t_flush [n_entries];
	logic [63:0] t_block [n_entries];
	logic [2:0] t_count [n_entries];
	logic [3:0][31:0] t_instr [n_entries];
	logic [3:0] t_is32 [n_entries];
	logic [3:0] t_ill [n_entries];
	logic [3:0] t_str [n_entries];
	logic [31:0] lfsr_state = 32'h48fa_b0c9;

	fetch_expand_top dut (
		.clk(clk),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_block(fetch_block),
		.flush(flush),
		.out_valid(out_valid),
		.out_count(out_count),
		.out_instr(out_instr),
		.out_is_32bit(out_is_32bit),
		.out_illegal(out_illegal),
		.out_straddle(out_straddle)
	);

	expand_checker chk (
		.clk(clk),
		.reset(reset),
		.out_valid(out_valid),
		.out_count(out_count),
		.out_instr(out_instr),
		.out_is_32bit(out_is_32bit),
		.out_illegal(out_illegal),
		.out_straddle(out_straddle)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output logic [31:0] w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	task automatic set_entry(
		input int i,
		input logic fl,
		input logic [63:0] blk,
		input logic [2:0] cnt,
		input logic [31:0] i0,
		input logic [31:0] i1,
		input logic [31:0] i2,
		input logic [31:0] i3,
		input logic [3:0] is32,
		input logic [3:0] ill,
		input logic [3:0] str
	);
		t_flush[i] = fl;
		t_block[i] = blk;
		t_count[i] = cnt;
		t_instr[i] = {i3, i2, i1, i0};
		t_is32[i] = is32;
		t_ill[i] = ill;
		t_str[i] = str;
	endtask

	task automatic build_table();
		logic [31:0] w0;
		logic [31:0] w1;
		// c.addi x10,1 / c.li x11,-1 / c.mv x12,x13 / c.add x14,x15
		set_entry(0, 1'b0, 64'h973e_8636_55fd_0505, 3'd4,
			32'h0015_0513, 32'hfff0_0593, 32'h00d0_0633, 32'h00f7_0733, 4'h0, 4'h0, 4'h0);
		// c.lw / c.sw / c.j 4 / c.beqz 8
		set_entry(1, 1'b0, 64'hc401_a011_c480_40c0, 3'd4,
			32'h0044_a403, 32'h0084_a423, 32'h0040_006f, 32'h0004_0463, 4'h0, 4'h0, 4'h0);
		// c.lui / c.addi16sp / c.srli / c.sub
		set_entry(2, 1'b0, 64'h8c89_800d_6141_6285, 3'd4,
			32'h0000_12b7, 32'h0101_0113, 32'h0034_5413, 32'h40a4_84b3, 4'h0, 4'h0, 4'h0);
		// c.lwsp / c.swsp / c.jr / c.ebreak
		set_entry(3, 1'b0, 64'h9002_8082_c406_4092, 3'd4,
			32'h0041_2083, 32'h0011_2423, 32'h0000_8067, 32'h0010_0073, 4'h0, 4'h0, 4'h0);
		// Zero, lui imm 0, jr x0, lwsp x0
		set_entry(4, 1'b0, 64'h4012_8002_6281_0000, 3'd4,
			32'h0000_0000, 32'h0000_02b7, 32'h0000_0067, 32'h0041_2003, 4'h0, 4'hf, 4'h0);
		// Reserved quadrant 0 / c.addi4spn / c.slli / c.bnez
		set_entry(5, 1'b0, 64'he089_018a_0040_8000, 3'd4,
			32'h0000_0000, 32'h0041_0413, 32'h0021_9193, 32'h0004_9163, 4'h0, 4'h1, 4'h0);
		// c.jal / c.andi / c.xor / c.jalr
		set_entry(6, 1'b0, 64'h9082_8c25_881d_2001, 3'd4,
			32'h0000_00ef, 32'h0074_7413, 32'h0094_4433, 32'h0000_80e7, 4'h0, 4'h0, 4'h0);
		// c.srai x8,3 / c.or x9,x10 / c.and x8,x15 / c.addi x10,-2
		set_entry(7, 1'b0, 64'h1579_8c7d_8cc9_840d, 3'd4,
			32'h4034_5413, 32'h00a4_e4b3, 32'h00f4_7433, 32'hffe5_0513, 4'h0, 4'h0, 4'h0);
		// Upper hw3 is held
		set_entry(8, 1'b0, 64'h0593_0015_0513_0505, 3'd2,
			32'h0015_0513, 32'h0015_0513, 32'h0, 32'h0, 4'h2, 4'h0, 4'h0);
		set_entry(9, 1'b0, 64'h973e_8636_55fd_00b0, 3'd4,
			32'h00b0_0593, 32'hfff0_0593, 32'h00d0_0633, 32'h00f7_0733, 4'h1, 4'h0, 4'h1);
		set_entry(10, 1'b0, 64'h0593_0505_0505_0505, 3'd3,
			32'h0015_0513, 32'h0015_0513, 32'h0015_0513, 32'h0, 4'h0, 4'h0, 4'h0);
		// Flush drops the held half
		set_entry(11, 1'b1, 64'h973e_8636_55fd_0505, 3'd4,
			32'h0015_0513, 32'hfff0_0593, 32'h00d0_0633, 32'h00f7_0733, 4'h0, 4'h0, 4'h0);
		for (int r = 0; r < n_rand; r++) begin
			rand_word(w0);
			rand_word(w1);
			w0[1:0] = 2'b11;
			w1[1:0] = 2'b11;
			set_entry(n_fixed + r, 1'b0, {w1, w0}, 3'd2, w0, w1, 32'h0, 32'h0,
				4'h3, 4'h0, 4'h0);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#((n_entries + 20) * 4);
		$display("Timeout: the DUT did not deliver all outputs in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		reset = 1'b1;
		fetch_valid = 1'b0;
		flush = 1'b0;
		fetch_block = '0;
		build_table();
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < n_entries; i++) begin
			@(posedge clk);
			fetch_valid <= 1'b1;
			flush <= t_flush[i];
			fetch_block <= t_block[i];
			chk.expect_entry(t_count[i], t_instr[i], t_is32[i], t_ill[i], t_str[i]);
			if (i % 3 == 2) begin
				@(posedge clk);
				fetch_valid <= 1'b0; // Idle gap
				flush <= 1'b0;
			end
		end
		@(posedge clk);
		fetch_valid <= 1'b0;
		flush <= 1'b0;
		while (chk.pending() != 0) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		$display("Checks done, errors: %0d", chk.error_count);
		if (chk.error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* verif/expand_checker.sv */
`timescale 1ns/1ps

module expand_checker (
	input logic clk,
	input logic reset,
	input logic out_valid,
	input logic [2:0] out_count,
	input logic [3:0][31:0] out_instr,
	input logic [3:0] out_is_32bit,
	input logic [3:0] out_illegal,
	input logic [3:0] out_straddle
);

	logic [2:0] q_count [$];
	logic [3:0][31:0] q_instr [$];
	logic [3:0] q_is32 [$];
	logic [3:0] q_ill [$];
	logic [3:0] q_str [$];
	int error_count = 0;

	task automatic expect_entry(
		input logic [2:0] cnt,
		input logic [3:0][31:0] ins,
		input logic [3:0] is32,
		input logic [3:0] ill,
		input logic [3:0] str
	);
		q_count.push_back(cnt);
		q_instr.push_back(ins);
		q_is32.push_back(is32);
		q_ill.push_back(ill);
		q_str.push_back(str);
	endtask

	function automatic int pending();
		pending = q_count.size();
	endfunction

	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Sample away from the clock edge
	always @(negedge clk) begin : sample
		logic [2:0] e_count;
		logic [3:0][31:0] e_instr;
		logic [3:0] e_is32;
		logic [3:0] e_ill;
		logic [3:0] e_str;
		if (!reset) begin
			if (out_valid) begin
				if (q_count.size() == 0) begin
					error_count++;
					$display("An output arrived with no block outstanding");
				end else begin
					e_count = q_count.pop_front();
					e_instr = q_instr.pop_front();
					e_is32 = q_is32.pop_front();
					e_ill = q_ill.pop_front();
					e_str = q_str.pop_front();
					compare_field("out_count", {29'h0, out_count}, {29'h0, e_count});
					for (int s = 0; s < 4; s++) begin
						compare_field($sformatf("out_instr[%0d]", s), out_instr[s], e_instr[s]);
					end
					compare_field("out_is_32bit", {28'h0, out_is_32bit}, {28'h0, e_is32});
					compare_field("out_illegal", {28'h0, out_illegal}, {28'h0, e_ill});
					compare_field("out_straddle", {28'h0, out_straddle}, {28'h0, e_str});
				end
			end else begin
				compare_field("out_count", {29'h0, out_count}, 32'h0); // Idle output
			end
		end
	end

endmodule

/* verif/expand_assertions.sv */
`timescale 1ns/1ps

module expand_assertions (
	input logic clk,
	input logic reset,
	input logic fetch_valid,
	input logic out_valid,
	input logic [rvc_pkg::count_width-1:0] out_count,
	input logic [rvc_pkg::n_lanes-1:0][31:0] out_instr,
	input logic [rvc_pkg::n_lanes-1:0] out_is_32bit,
	input logic [rvc_pkg::n_lanes-1:0] out_illegal,
	input logic [rvc_pkg::n_lanes-1:0] out_straddle
);

	count_limit: assert property (@(posedge clk) disable iff (reset) out_count <= 3'd4)
		else $error("out_count is above the number of lanes");

	// Unused slots carry nothing
	for (genvar g = 0; g < rvc_pkg::n_lanes; g++) begin : g_slot
		slot_zero: assert property (@(posedge clk) disable iff (reset)
			(out_count <= 3'(g)) |-> (out_instr[g] == 32'h0 && !out_is_32bit[g]
			&& !out_illegal[g] && !out_straddle[g]))
			else $error("Slot %0d at or above out_count is not zero", g);
	end

	valid_follows: assert property (@(posedge clk) disable iff (reset)
		out_valid == $past(fetch_valid))
		else $error("out_valid does not follow fetch_valid by one cycle");

endmodule

bind lane_packer expand_assertions u_asrt (.*);

/* design/fetch_expand_top.sv */
`timescale 1ns/1ps

module fetch_expand_top (
	input logic clk,
	input logic reset,
	input logic fetch_valid,
	input logic [rvc_pkg::block_width-1:0] fetch_block,
	input logic flush,
	output logic out_valid,
	output logic [rvc_pkg::count_width-1:0] out_count,
	output logic [rvc_pkg::n_lanes-1:0][31:0] out_instr,
	output logic [rvc_pkg::n_lanes-1:0] out_is_32bit,
	output logic [rvc_pkg::n_lanes-1:0] out_illegal,
	output logic [rvc_pkg::n_lanes-1:0] out_straddle
);

	raw_lane_if raw_lanes [rvc_pkg::n_lanes] ();
	exp_lane_if exp_lanes [rvc_pkg::n_lanes] ();

	fetch_aligner u_aligner (
		.clk(clk),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.flush(flush),
		.fetch_block(fetch_block),
		.lanes(raw_lanes)
	);

	// One expander per lane
	for (genvar g = 0; g < rvc_pkg::n_lanes; g++) begin : g_exp
		rvc_expander u_exp (
			.lane_in(raw_lanes[g]),
			.lane_out(exp_lanes[g])
		);
	end

	lane_packer u_packer (
		.clk(clk),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.lanes(exp_lanes),
		.out_valid(out_valid),
		.out_count(out_count),
		.out_instr(out_instr),
		.out_is_32bit(out_is_32bit),
		.out_illegal(out_illegal),
		.out_straddle(out_straddle)
	);

endmodule

/* design/lane_packer.sv */
`timescale 1ns/1ps

module lane_packer (
	input logic clk,
	input logic reset,
	input logic fetch_valid,
	exp_lane_if.dst lanes [rvc_pkg::n_lanes],
	output logic out_valid,
	output logic [rvc_pkg::count_width-1:0] out_count,
	output logic [rvc_pkg::n_lanes-1:0][31:0] out_instr,
	output logic [rvc_pkg::n_lanes-1:0] out_is_32bit,
	output logic [rvc_pkg::n_lanes-1:0] out_illegal,
	output logic [rvc_pkg::n_lanes-1:0] out_straddle
);

	logic [rvc_pkg::n_lanes-1:0] lane_valid;
	logic [rvc_pkg::n_lanes-1:0][31:0] lane_instr;
	logic [rvc_pkg::n_lanes-1:0] lane_is32;
	logic [rvc_pkg::n_lanes-1:0] lane_ill;
	logic [rvc_pkg::n_lanes-1:0] lane_str;

	logic [rvc_pkg::count_width-1:0] count_n;
	logic [rvc_pkg::n_lanes-1:0][31:0] instr_n;
	logic [rvc_pkg::n_lanes-1:0] is32_n;
	logic [rvc_pkg::n_lanes-1:0] ill_n;
	logic [rvc_pkg::n_lanes-1:0] str_n;

	for (genvar g = 0; g < rvc_pkg::n_lanes; g++) begin : g_lane
		assign lane_valid[g] = lanes[g].valid & fetch_valid; // Idle cycles pack nothing
		assign lane_instr[g] = lanes[g].instr;
		assign lane_is32[g] = lanes[g].is_32bit;
		assign lane_ill[g] = lanes[g].illegal;
		assign lane_str[g] = lanes[g].straddle;
	end

	// Lane i goes to slot k with k valid lanes below it
	always_comb begin
		int k;
		k = 0;
		instr_n = '0;
		is32_n = '0;
		ill_n = '0;
		str_n = '0;
		for (int i = 0; i < rvc_pkg::n_lanes; i++) begin
			if (lane_valid[i]) begin
				instr_n[k] = lane_instr[i];
				is32_n[k] = lane_is32[i];
				ill_n[k] = lane_ill[i];
				str_n[k] = lane_str[i];
				k++;
			end
		end
		count_n = rvc_pkg::count_width'(k);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_count <= '0;
			out_instr <= '0;
			out_is_32bit <= '0;
			out_illegal <= '0;
			out_straddle <= '0;
		end else begin
			out_valid <= fetch_valid;
			out_count <= count_n;
			out_instr <= instr_n;
			out_is_32bit <= is32_n;
			out_illegal <= ill_n;
			out_straddle <= str_n;
		end
	end

endmodule

/* design/rvc_expander.sv */
`timescale 1ns/1ps

module rvc_expander (
	raw_lane_if.dst lane_in,
	exp_lane_if.src lane_out
);

	rvc_pkg::instr_word_u w;
	logic [15:0] c;
	logic [4:0] rd_l;  // Also rs1 in CR/CI
	logic [4:0] rs2_l;
	logic [4:0] rs1_s; // Also rd in CA/CB
	logic [4:0] rs2_s; // Also rd in CIW/CL
	logic [31:0] imm_ci;
	logic [31:0] imm_cj;
	logic [31:0] imm_cb;
	logic [31:0] res;
	logic is_32;
	logic bad;

	function automatic logic [31:0] regs(
		input logic [4:0] rd,
		input logic [4:0] rs1,
		input logic [4:0] rs2
	);
		regs = ({27'h0, rd} << rvc_pkg::rd_lsb)
			| ({27'h0, rs1} << rvc_pkg::rs1_lsb)
			| ({27'h0, rs2} << rvc_pkg::rs2_lsb);
	endfunction

	assign w = lane_in.word;
	assign c = w.hw.lo;

	assign rd_l = c[11:7];
	assign rs2_l = c[6:2];
	assign rs1_s = {2'b01, c[9:7]};
	assign rs2_s = {2'b01, c[4:2]};

	assign imm_ci = {{7{c[12]}}, c[6:2], 20'h0};
	assign imm_cj = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
		{9{c[12]}}, 12'h0};
	// Branch offset split over funct7 and rd positions
	assign imm_cb = {{4{c[12]}}, c[6:5], c[2], 13'h0, c[11:10], c[4:3], c[12], 7'h0};

	always_comb begin
		res = 32'h0;
		is_32 = 1'b0;
		bad = 1'b0;
		if (w.base.opcode[1:0] == 2'b11) begin
			res = w;
			is_32 = 1'b1;
		end else begin
			casez (c)
			16'h0000: bad = 1'b1;
			rvc_pkg::rv_c_addi4spn: res = rvc_pkg::rv_noz_addi | regs(rs2_s, 5'd2, 5'd0)
				| {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, 20'h0};
			rvc_pkg::rv_c_lw: res = rvc_pkg::rv_noz_lw | regs(rs2_s, rs1_s, 5'd0)
				| {5'h0, c[5], c[12:10], c[6], 2'b00, 20'h0};
			rvc_pkg::rv_c_sw: res = rvc_pkg::rv_noz_sw | regs(5'd0, rs1_s, rs2_s)
				| {5'h0, c[5], c[12], 13'h0, c[11:10], c[6], 2'b00, 7'h0};
			rvc_pkg::rv_c_addi: res = rvc_pkg::rv_noz_addi | regs(rd_l, rd_l, 5'd0) | imm_ci;
			rvc_pkg::rv_c_jal: res = rvc_pkg::rv_noz_jal | regs(5'd1, 5'd0, 5'd0) | imm_cj;
			rvc_pkg::rv_c_j: res = rvc_pkg::rv_noz_jal | imm_cj;
			rvc_pkg::rv_c_li: res = rvc_pkg::rv_noz_addi | regs(rd_l, 5'd0, 5'd0) | imm_ci;
			rvc_pkg::rv_c_lui: begin
				if (rd_l == 5'd2) begin
					res = rvc_pkg::rv_noz_addi | regs(5'd2, 5'd2, 5'd0)
						| {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'h0, 20'h0};
				end else begin
					res = rvc_pkg::rv_noz_lui | regs(rd_l, 5'd0, 5'd0)
						| {{15{c[12]}}, c[6:2], 12'h0};
				end
				bad = ~|{c[12], c[6:2]}; // Reserved when imm is zero
			end
			rvc_pkg::rv_c_slli: res = rvc_pkg::rv_noz_slli | regs(rd_l, rd_l, 5'd0) | imm_ci;
			rvc_pkg::rv_c_srli: res = rvc_pkg::rv_noz_srli | regs(rs1_s, rs1_s, 5'd0) | imm_ci;
			rvc_pkg::rv_c_srai: res = rvc_pkg::rv_noz_srai | regs(rs1_s, rs1_s, 5'd0) | imm_ci;
			rvc_pkg::rv_c_andi: res = rvc_pkg::rv_noz_andi | regs(rs1_s, rs1_s, 5'd0) | imm_ci;
			rvc_pkg::rv_c_sub: res = rvc_pkg::rv_noz_sub | regs(rs1_s, rs1_s, rs2_s);
			rvc_pkg::rv_c_xor: res = rvc_pkg::rv_noz_xor | regs(rs1_s, rs1_s, rs2_s);
			rvc_pkg::rv_c_or: res = rvc_pkg::rv_noz_or | regs(rs1_s, rs1_s, rs2_s);
			rvc_pkg::rv_c_and: res = rvc_pkg::rv_noz_and | regs(rs1_s, rs1_s, rs2_s);
			rvc_pkg::rv_c_add: begin
				if (|rs2_l) begin
					res = rvc_pkg::rv_noz_add | regs(rd_l, rd_l, rs2_l);
				end else if (|rd_l) begin
					res = rvc_pkg::rv_noz_jalr | regs(5'd1, rd_l, 5'd0);
				end else begin
					res = rvc_pkg::rv_noz_ebreak;
				end
			end
			rvc_pkg::rv_c_mv: begin
				if (|rs2_l) begin
					res = rvc_pkg::rv_noz_add | regs(rd_l, 5'd0, rs2_l);
				end else begin
					res = rvc_pkg::rv_noz_jalr | regs(5'd0, rd_l, 5'd0);
					bad = ~|rd_l; // jr x0
				end
			end
			rvc_pkg::rv_c_lwsp: begin
				res = rvc_pkg::rv_noz_lw | regs(rd_l, 5'd2, 5'd0)
					| {4'h0, c[3:2], c[12], c[6:4], 2'b00, 20'h0};
				bad = ~|rd_l;
			end
			rvc_pkg::rv_c_swsp: res = rvc_pkg::rv_noz_sw | regs(5'd0, 5'd2, rs2_l)
				| {4'h0, c[8:7], c[12], 13'h0, c[11:9], 2'b00, 7'h0};
			rvc_pkg::rv_c_beqz: res = rvc_pkg::rv_noz_beq | regs(5'd0, rs1_s, 5'd0) | imm_cb;
			rvc_pkg::rv_c_bnez: res = rvc_pkg::rv_noz_bne | regs(5'd0, rs1_s, 5'd0) | imm_cb;
			default: bad = 1'b1;
			endcase
		end
	end

	assign lane_out.valid = lane_in.valid;
	assign lane_out.instr = res;
	assign lane_out.is_32bit = is_32;
	assign lane_out.illegal = bad;
	assign lane_out.straddle = lane_in.straddle;

endmodule

/* design/fetch_aligner.sv */
`timescale 1ns/1ps

module fetch_aligner (
	input logic clk,
	input logic reset,
	input logic fetch_valid,
	input logic flush,
	input logic [rvc_pkg::block_width-1:0] fetch_block,
	raw_lane_if.src lanes [rvc_pkg::n_lanes]
);

	localparam int pos_w = $clog2(rvc_pkg::hw_per_block);

	logic [15:0] hw [rvc_pkg::hw_per_block+1];
	logic [15:0] held_hw;
	logic held_valid;
	logic pending;
	logic hold_next;

	logic valid_c [rvc_pkg::n_lanes];
	logic straddle_c [rvc_pkg::n_lanes];
	rvc_pkg::instr_word_u word_c [rvc_pkg::n_lanes];
	logic [pos_w-1:0] pos_c [rvc_pkg::n_lanes];

	always_comb begin
		for (int p = 0; p < rvc_pkg::hw_per_block; p++) begin
			hw[p] = fetch_block[16*p +: 16];
		end
		hw[rvc_pkg::hw_per_block] = 16'h0; // Pad past the last halfword
	end

	// Flush wins over the held half on the same edge
	assign pending = held_valid && !flush;

	always_comb begin
		logic skip;
		skip = pending;
		hold_next = 1'b0;
		for (int p = 0; p < rvc_pkg::n_lanes; p++) begin
			valid_c[p] = 1'b0;
			straddle_c[p] = 1'b0;
			word_c[p] = '0;
			pos_c[p] = pos_w'(p);
		end

		if (pending) begin
			valid_c[0] = 1'b1;
			straddle_c[0] = 1'b1;
			word_c[0].hw.lo = held_hw;
			word_c[0].hw.hi = hw[0];
			pos_c[0] = pos_w'(rvc_pkg::hw_per_block - 1); // Started in previous block
		end

		for (int p = 0; p < rvc_pkg::hw_per_block; p++) begin
			if (skip) begin
				skip = 1'b0; // Upper half of a 32-bit word
			end else if (hw[p][1:0] == 2'b11 && p == rvc_pkg::hw_per_block - 1) begin
				hold_next = 1'b1;
			end else begin
				valid_c[p] = 1'b1;
				word_c[p].hw.lo = hw[p];
				if (hw[p][1:0] == 2'b11) begin
					word_c[p].hw.hi = hw[p+1];
					skip = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			held_valid <= 1'b0;
		end else if (fetch_valid) begin
			held_valid <= hold_next;
		end else if (flush) begin
			held_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid && hold_next) begin
			held_hw <= hw[rvc_pkg::hw_per_block-1];
		end
	end

	for (genvar g = 0; g < rvc_pkg::n_lanes; g++) begin : g_lane
		assign lanes[g].valid = valid_c[g];
		assign lanes[g].word = word_c[g];
		assign lanes[g].straddle = straddle_c[g];
		assign lanes[g].slot_pos = pos_c[g];
	end

endmodule

/* design/lane_ifs.sv */
`timescale 1ns/1ps

// Aligner to expander
interface raw_lane_if;
	logic valid;
	rvc_pkg::instr_word_u word;
	logic straddle; // Joined with the held halfword
	logic [$clog2(rvc_pkg::hw_per_block)-1:0] slot_pos;

	modport src (
		output valid,
		output word,
		output straddle,
		output slot_pos
	);

	modport dst (
		input valid,
		input word,
		input straddle,
		input slot_pos
	);
endinterface

// Expander to packer
interface exp_lane_if;
	logic valid;
	logic [31:0] instr;
	logic is_32bit;
	logic illegal;
	logic straddle;

	modport src (
		output valid,
		output instr,
		output is_32bit,
		output illegal,
		output straddle
	);

	modport dst (
		input valid,
		input instr,
		input is_32bit,
		input illegal,
		input straddle
	);
endinterface

/* design/rvc_pkg.sv */
package rvc_pkg;

	localparam int n_lanes = 4;
	localparam int hw_per_block = 4;
	localparam int block_width = 64;
	localparam int count_width = 3;

	// Field positions in a base instruction
	localparam int rd_lsb = 7;
	localparam int rs1_lsb = 15;
	localparam int rs2_lsb = 20;

	// Compressed match patterns with ? as don't care in casez
	localparam logic [15:0] rv_c_addi4spn = 16'b000???????????00;
	localparam logic [15:0] rv_c_lw       = 16'b010???????????00;
	localparam logic [15:0] rv_c_sw       = 16'b110???????????00;
	localparam logic [15:0] rv_c_addi     = 16'b000???????????01;
	localparam logic [15:0] rv_c_jal      = 16'b001???????????01;
	localparam logic [15:0] rv_c_li       = 16'b010???????????01;
	localparam logic [15:0] rv_c_lui      = 16'b011???????????01; // Also addi16sp
	localparam logic [15:0] rv_c_srli     = 16'b100000????????01;
	localparam logic [15:0] rv_c_srai     = 16'b100001????????01;
	localparam logic [15:0] rv_c_andi     = 16'b100?10????????01;
	localparam logic [15:0] rv_c_sub      = 16'b100011???00???01;
	localparam logic [15:0] rv_c_xor      = 16'b100011???01???01;
	localparam logic [15:0] rv_c_or       = 16'b100011???10???01;
	localparam logic [15:0] rv_c_and      = 16'b100011???11???01;
	localparam logic [15:0] rv_c_j        = 16'b101???????????01;
	localparam logic [15:0] rv_c_beqz     = 16'b110???????????01;
	localparam logic [15:0] rv_c_bnez     = 16'b111???????????01;
	localparam logic [15:0] rv_c_slli     = 16'b0000??????????10;
	localparam logic [15:0] rv_c_lwsp     = 16'b010???????????10;
	localparam logic [15:0] rv_c_mv       = 16'b1000??????????10; // Also jr
	localparam logic [15:0] rv_c_add      = 16'b1001??????????10; // Also jalr, ebreak
	localparam logic [15:0] rv_c_swsp     = 16'b110???????????10;

	// Base instructions with register and immediate fields zeroed
	localparam logic [31:0] rv_noz_beq    = 32'h0000_0063;
	localparam logic [31:0] rv_noz_bne    = 32'h0000_1063;
	localparam logic [31:0] rv_noz_jal    = 32'h0000_006f;
	localparam logic [31:0] rv_noz_jalr   = 32'h0000_0067;
	localparam logic [31:0] rv_noz_lui    = 32'h0000_0037;
	localparam logic [31:0] rv_noz_addi   = 32'h0000_0013;
	localparam logic [31:0] rv_noz_slli   = 32'h0000_1013;
	localparam logic [31:0] rv_noz_srli   = 32'h0000_5013;
	localparam logic [31:0] rv_noz_srai   = 32'h4000_5013;
	localparam logic [31:0] rv_noz_andi   = 32'h0000_7013;
	localparam logic [31:0] rv_noz_add    = 32'h0000_0033;
	localparam logic [31:0] rv_noz_sub    = 32'h4000_0033;
	localparam logic [31:0] rv_noz_xor    = 32'h0000_4033;
	localparam logic [31:0] rv_noz_or     = 32'h0000_6033;
	localparam logic [31:0] rv_noz_and    = 32'h0000_7033;
	localparam logic [31:0] rv_noz_lw     = 32'h0000_2003;
	localparam logic [31:0] rv_noz_sw     = 32'h0000_2023;
	localparam logic [31:0] rv_noz_ebreak = 32'h0010_0073;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} base_fmt_t;

	typedef struct packed {
		logic [15:0] hi;
		logic [15:0] lo;
	} halves_t;

	// One word as R-type fields or as two parcels
	typedef union packed {
		base_fmt_t base;
		halves_t hw;
	} instr_word_u;

endpackage
